// ==== hdl/bridge_defines.svh ====
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// byte address into memory
`define ADDR_W 32

// AXI data bus width, one beat
`define BEAT_W 32

// beats in one cache line, burst length is this minus one
`define LINE_BEATS 16

// AXI id field width
`define AXI_ID_W 4

`endif

// ==== hdl/axi_pkg.sv ====
`include "bridge_defines.svh"

package axi_pkg;

    typedef logic [1:0] axi_burst_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_resp_t;
    typedef logic [7:0] axi_len_t;

    localparam axi_burst_t AXI_BURST_INCR = 2'b01;   // only burst type used

    localparam axi_size_t AXI_SIZE_4B = 3'd2;        // 2^2 bytes per beat

    localparam axi_len_t AXI_LINE_LEN = axi_len_t'(`LINE_BEATS - 1);   // one full line

    localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
    localparam axi_resp_t AXI_RESP_EXOKAY = 2'b01;
    localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;
    localparam axi_resp_t AXI_RESP_DECERR = 2'b11;

endpackage

// ==== hdl/cache_line_pkg.sv ====
`include "bridge_defines.svh"

package cache_line_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;

    // one AXI beat, one word of a line
    typedef logic [`BEAT_W-1:0] beat_t;

    // beat 0 sits in the low bits
    typedef logic [`LINE_BEATS*`BEAT_W-1:0] line_t;

    // value doubles as the AR id
    typedef enum logic
    {
        ICACHE = 1'b0,
        DCACHE = 1'b1
    } requester_t;

endpackage

// ==== hdl/line_req_if.sv ====
`timescale 1ns/1ps

interface line_req_if import cache_line_pkg::*; ();

    logic       valid;     // arbiter has a winner
    logic       ready;     // reader is idle
    addr_t      addr;      // line address of the winner
    requester_t who;       // which cache gets the line

    modport arbiter
    (
        output valid, addr, who,
        input  ready
    );

    modport engine
    (
        input  valid, addr, who,
        output ready
    );

endinterface

// ==== hdl/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter import cache_line_pkg::*;
(
    input  logic         i_i_rd_valid,
    input  addr_t        i_i_rd_addr,
    output logic         o_i_rd_ready,
    input  logic         i_d_rd_valid,
    input  addr_t        i_d_rd_addr,
    output logic         o_d_rd_ready,
    line_req_if.arbiter  o_req
);

    // data cache always wins a tie
    assign o_req.valid = i_d_rd_valid | i_i_rd_valid;

    always_comb
    begin
        if (i_d_rd_valid)
        begin
            o_req.addr = i_d_rd_addr;
            o_req.who  = DCACHE;
        end
        else
        begin
            o_req.addr = i_i_rd_addr;
            o_req.who  = ICACHE;
        end
    end

    // grant goes back to the winner only
    assign o_d_rd_ready = o_req.ready;
    assign o_i_rd_ready = o_req.ready & ~i_d_rd_valid;

endmodule

// ==== hdl/axi_line_reader.sv ====
`timescale 1ns/1ps
`include "bridge_defines.svh"

module axi_line_reader import axi_pkg::*, cache_line_pkg::*;
(
    input  logic                 aclk,
    input  logic                 aresetn,
    line_req_if.engine           i_req,
    output logic [`AXI_ID_W-1:0] o_ar_id,
    output addr_t                o_ar_addr,
    output axi_len_t             o_ar_len,
    output axi_size_t            o_ar_size,
    output axi_burst_t           o_ar_burst,
    output logic                 o_ar_valid,
    input  logic                 i_ar_ready,
    input  beat_t                i_r_data,
    input  axi_resp_t            i_r_resp,
    input  logic                 i_r_last,
    input  logic                 i_r_valid,
    output logic                 o_r_ready,
    output logic                 o_i_rsp_valid,
    output logic                 o_d_rsp_valid,
    output line_t                o_rsp_line,
    output logic                 o_rsp_err
);

    typedef enum logic [1:0]
    {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_RESP
    } rd_state_t;

    rd_state_t  state;
    addr_t      addr_q;
    requester_t who_q;
    line_t      line_q;
    logic       err_q;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state <= RD_IDLE;
            who_q <= ICACHE;
            err_q <= 1'b0;
        end
        else
        begin
            case (state)
                RD_IDLE:
                begin
                    if (i_req.valid)                    // ready is high in idle
                    begin
                        who_q <= i_req.who;
                        err_q <= 1'b0;
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR:
                begin
                    if (i_ar_ready)
                        state <= RD_DATA;
                end
                RD_DATA:
                begin
                    if (i_r_valid)
                    begin
                        err_q <= err_q | (i_r_resp != AXI_RESP_OKAY);   // sticky
                        if (i_r_last)
                            state <= RD_RESP;
                    end
                end
                default:
                    state <= RD_IDLE;                   // one-cycle response
            endcase
        end
    end

    // address and line are payload only
    always_ff @(posedge aclk)
    begin
        if (i_req.valid && i_req.ready)
            addr_q <= i_req.addr;
        if (o_r_ready && i_r_valid)
            line_q <= {i_r_data, line_q[$bits(line_t)-1:`BEAT_W]};   // beat 0 ends low
    end

    assign i_req.ready = (state == RD_IDLE);

    assign o_ar_id    = {{(`AXI_ID_W-1){1'b0}}, who_q};
    assign o_ar_addr  = addr_q;
    assign o_ar_len   = AXI_LINE_LEN;
    assign o_ar_size  = AXI_SIZE_4B;
    assign o_ar_burst = AXI_BURST_INCR;
    assign o_ar_valid = (state == RD_ADDR);
    assign o_r_ready  = (state == RD_DATA);

    assign o_i_rsp_valid = (state == RD_RESP) && (who_q == ICACHE);
    assign o_d_rsp_valid = (state == RD_RESP) && (who_q == DCACHE);
    assign o_rsp_line    = line_q;
    assign o_rsp_err     = err_q;

endmodule

// ==== hdl/beat_serializer.sv ====
`timescale 1ns/1ps
`include "bridge_defines.svh"

module beat_serializer import cache_line_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  i_load,
    input  line_t i_line,
    input  logic  i_advance,
    output beat_t o_beat,
    output logic  o_last
);

    localparam int CNT_W = $clog2(`LINE_BEATS);

    line_t            line_q;
    logic [CNT_W-1:0] cnt;      // beats already sent

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            cnt <= '0;
        else if (i_load)
            cnt <= '0;
        else if (i_advance)
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge aclk)
    begin
        if (i_load)
            line_q <= i_line;
        else if (i_advance)
            line_q <= line_q >> `BEAT_W;    // next beat drops into the low word
    end

    assign o_beat = line_q[`BEAT_W-1:0];
    assign o_last = (cnt == CNT_W'(`LINE_BEATS - 1));

endmodule

// ==== hdl/axi_line_writer.sv ====
`timescale 1ns/1ps
`include "bridge_defines.svh"

module axi_line_writer import axi_pkg::*, cache_line_pkg::*;
(
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 i_d_wr_valid,
    input  addr_t                i_d_wr_addr,
    input  line_t                i_d_wr_line,
    output logic                 o_d_wr_ready,
    output logic                 o_d_wr_done,
    output axi_resp_t            o_d_wr_resp,
    output addr_t                o_aw_addr,
    output axi_len_t             o_aw_len,
    output axi_size_t            o_aw_size,
    output axi_burst_t           o_aw_burst,
    output logic                 o_aw_valid,
    input  logic                 i_aw_ready,
    output beat_t                o_w_data,
    output logic [`BEAT_W/8-1:0] o_w_strb,
    output logic                 o_w_last,
    output logic                 o_w_valid,
    input  logic                 i_w_ready,
    input  axi_resp_t            i_b_resp,
    input  logic                 i_b_valid,
    output logic                 o_b_ready
);

    typedef enum logic [1:0]
    {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    wr_state_t state;
    addr_t     addr_q;
    axi_resp_t resp_q;
    logic      done_q;
    logic      load;
    logic      advance;

    assign load    = i_d_wr_valid & o_d_wr_ready;
    assign advance = o_w_valid & i_w_ready;          // one W handshake

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state  <= WR_IDLE;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= (state == WR_RESP) && i_b_valid;   // pulse after B
            case (state)
                WR_IDLE:
                    if (i_d_wr_valid)
                        state <= WR_ADDR;
                WR_ADDR:
                    if (i_aw_ready)
                        state <= WR_DATA;
                WR_DATA:
                    if (advance && o_w_last)
                        state <= WR_RESP;
                default:
                    if (i_b_valid)
                        state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (load)
            addr_q <= i_d_wr_addr;
        if (o_b_ready && i_b_valid)
            resp_q <= i_b_resp;
    end

    beat_serializer i_beat_serializer
    (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_load    (load),
        .i_line    (i_d_wr_line),
        .i_advance (advance),
        .o_beat    (o_w_data),
        .o_last    (o_w_last)
    );

    assign o_d_wr_ready = (state == WR_IDLE);
    assign o_d_wr_done  = done_q;
    assign o_d_wr_resp  = resp_q;

    assign o_aw_addr  = addr_q;
    assign o_aw_len   = AXI_LINE_LEN;
    assign o_aw_size  = AXI_SIZE_4B;
    assign o_aw_burst = AXI_BURST_INCR;
    assign o_aw_valid = (state == WR_ADDR);
    assign o_w_strb   = '1;                          // always a full line
    assign o_w_valid  = (state == WR_DATA);
    assign o_b_ready  = (state == WR_RESP);

endmodule

// ==== hdl/cache_axi_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_defines.svh"

module cache_axi_bridge import axi_pkg::*, cache_line_pkg::*;
(
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 i_i_rd_valid,
    input  addr_t                i_i_rd_addr,
    output logic                 o_i_rd_ready,
    output logic                 o_i_rsp_valid,
    output line_t                o_i_rsp_line,
    output logic                 o_i_rsp_err,
    input  logic                 i_d_rd_valid,
    input  addr_t                i_d_rd_addr,
    output logic                 o_d_rd_ready,
    output logic                 o_d_rsp_valid,
    output line_t                o_d_rsp_line,
    output logic                 o_d_rsp_err,
    input  logic                 i_d_wr_valid,
    input  addr_t                i_d_wr_addr,
    input  line_t                i_d_wr_line,
    output logic                 o_d_wr_ready,
    output logic                 o_d_wr_done,
    output axi_resp_t            o_d_wr_resp,
    output logic [`AXI_ID_W-1:0] o_ar_id,
    output addr_t                o_ar_addr,
    output axi_len_t             o_ar_len,
    output axi_size_t            o_ar_size,
    output axi_burst_t           o_ar_burst,
    output logic                 o_ar_valid,
    input  logic                 i_ar_ready,
    input  beat_t                i_r_data,
    input  axi_resp_t            i_r_resp,
    input  logic                 i_r_last,
    input  logic                 i_r_valid,
    output logic                 o_r_ready,
    output addr_t                o_aw_addr,
    output axi_len_t             o_aw_len,
    output axi_size_t            o_aw_size,
    output axi_burst_t           o_aw_burst,
    output logic                 o_aw_valid,
    input  logic                 i_aw_ready,
    output beat_t                o_w_data,
    output logic [`BEAT_W/8-1:0] o_w_strb,
    output logic                 o_w_last,
    output logic                 o_w_valid,
    input  logic                 i_w_ready,
    input  axi_resp_t            i_b_resp,
    input  logic                 i_b_valid,
    output logic                 o_b_ready
);

    line_t rsp_line;
    logic  rsp_err;

    line_req_if i_line_req_if ();   // granted read, arbiter to reader

    read_arbiter i_read_arbiter
    (
        .i_i_rd_valid (i_i_rd_valid),
        .i_i_rd_addr  (i_i_rd_addr),
        .o_i_rd_ready (o_i_rd_ready),
        .i_d_rd_valid (i_d_rd_valid),
        .i_d_rd_addr  (i_d_rd_addr),
        .o_d_rd_ready (o_d_rd_ready),
        .o_req        (i_line_req_if.arbiter)
    );

    axi_line_reader i_axi_line_reader
    (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_req         (i_line_req_if.engine),
        .o_ar_id       (o_ar_id),
        .o_ar_addr     (o_ar_addr),
        .o_ar_len      (o_ar_len),
        .o_ar_size     (o_ar_size),
        .o_ar_burst    (o_ar_burst),
        .o_ar_valid    (o_ar_valid),
        .i_ar_ready    (i_ar_ready),
        .i_r_data      (i_r_data),
        .i_r_resp      (i_r_resp),
        .i_r_last      (i_r_last),
        .i_r_valid     (i_r_valid),
        .o_r_ready     (o_r_ready),
        .o_i_rsp_valid (o_i_rsp_valid),
        .o_d_rsp_valid (o_d_rsp_valid),
        .o_rsp_line    (rsp_line),
        .o_rsp_err     (rsp_err)
    );

    // one line register serves both caches, the valids tell them apart
    assign o_i_rsp_line = rsp_line;
    assign o_d_rsp_line = rsp_line;
    assign o_i_rsp_err  = rsp_err;
    assign o_d_rsp_err  = rsp_err;

    axi_line_writer i_axi_line_writer
    (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_d_wr_valid (i_d_wr_valid),
        .i_d_wr_addr  (i_d_wr_addr),
        .i_d_wr_line  (i_d_wr_line),
        .o_d_wr_ready (o_d_wr_ready),
        .o_d_wr_done  (o_d_wr_done),
        .o_d_wr_resp  (o_d_wr_resp),
        .o_aw_addr    (o_aw_addr),
        .o_aw_len     (o_aw_len),
        .o_aw_size    (o_aw_size),
        .o_aw_burst   (o_aw_burst),
        .o_aw_valid   (o_aw_valid),
        .i_aw_ready   (i_aw_ready),
        .o_w_data     (o_w_data),
        .o_w_strb     (o_w_strb),
        .o_w_last     (o_w_last),
        .o_w_valid    (o_w_valid),
        .i_w_ready    (i_w_ready),
        .i_b_resp     (i_b_resp),
        .i_b_valid    (i_b_valid),
        .o_b_ready    (o_b_ready)
    );

endmodule

// ==== test/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model import axi_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [31:0] i_ar_addr,
    input  axi_len_t    i_ar_len,
    input  axi_burst_t  i_ar_burst,
    input  logic        i_ar_valid,
    output logic        o_ar_ready,
    output logic [31:0] o_r_data,
    output axi_resp_t   o_r_resp,
    output logic        o_r_last,
    output logic        o_r_valid,
    input  logic        i_r_ready,
    input  logic [31:0] i_aw_addr,
    input  axi_len_t    i_aw_len,
    input  axi_burst_t  i_aw_burst,
    input  logic        i_aw_valid,
    output logic        o_aw_ready,
    input  logic [31:0] i_w_data,
    input  logic        i_w_last,
    input  logic        i_w_valid,
    output logic        o_w_ready,
    output axi_resp_t   o_b_resp,
    output logic        o_b_valid,
    input  logic        i_b_ready,
    output logic [9:0]  o_seen_ar,     // len and burst of the last AR
    output logic [9:0]  o_seen_aw      // len and burst of the last AW
);

    logic [31:0] mem [0:16383];
    logic        rd_busy;
    logic        rd_err;
    logic [31:0] rd_ptr;
    axi_len_t    rd_cnt;
    axi_len_t    rd_len;
    logic        wr_busy;
    logic        wr_err;
    logic        b_pend;
    logic [31:0] wr_ptr;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic logic err_window(input logic [31:0] a);
        return (a >= 32'h0000_F000) && (a <= 32'h0000_FFFF);
    endfunction

    initial
    begin
        for (int i = 0; i < 16384; i++)
            mem[i] = fill_word(i * 4);
        {o_ar_ready, o_r_valid, o_r_last, o_aw_ready, o_w_ready, o_b_valid} = '0;
        {o_r_data, o_r_resp, o_b_resp, o_seen_ar, o_seen_aw} = '0;
        {rd_busy, rd_err, rd_ptr, rd_cnt, rd_len} = '0;
        {wr_busy, wr_err, b_pend, wr_ptr} = '0;
    end

    // read side, handshakes sampled at the edge, outputs 1 ns later
    always @(posedge aclk)
    begin
        if (!aresetn)
            rd_busy = 1'b0;
        else if (!rd_busy && i_ar_valid && o_ar_ready)
        begin
            rd_busy   = 1'b1;
            rd_ptr    = i_ar_addr;
            rd_cnt    = '0;
            rd_len    = i_ar_len;
            rd_err    = err_window(i_ar_addr);
            o_seen_ar = {i_ar_len, i_ar_burst};
        end
        else if (rd_busy && o_r_valid && i_r_ready)
        begin
            rd_busy = !o_r_last;
            rd_ptr  = rd_ptr + 4;
            rd_cnt  = rd_cnt + 1'b1;
        end
        #1;
        o_ar_ready = aresetn && !rd_busy && ($urandom_range(3) != 0);
        o_r_valid  = rd_busy && ((o_r_valid && !i_r_ready) || ($urandom_range(3) != 0));
        o_r_data   = mem[rd_ptr[15:2]];
        o_r_resp   = rd_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        o_r_last   = (rd_cnt == rd_len);
    end

    // write side, error window writes are dropped
    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_busy = 1'b0;
            b_pend  = 1'b0;
        end
        else if (!wr_busy && i_aw_valid && o_aw_ready)
        begin
            wr_busy   = 1'b1;
            wr_ptr    = i_aw_addr;
            wr_err    = err_window(i_aw_addr);
            o_seen_aw = {i_aw_len, i_aw_burst};
        end
        else if (wr_busy && !b_pend && i_w_valid && o_w_ready)
        begin
            if (!wr_err)
                mem[wr_ptr[15:2]] = i_w_data;
            wr_ptr = wr_ptr + 4;
            b_pend = i_w_last;
        end
        else if (b_pend && o_b_valid && i_b_ready)
        begin
            b_pend  = 1'b0;
            wr_busy = 1'b0;
        end
        #1;
        o_aw_ready = aresetn && !wr_busy && ($urandom_range(3) != 0);
        o_w_ready  = wr_busy && !b_pend && ($urandom_range(3) != 0);
        o_b_valid  = b_pend && ((o_b_valid && !i_b_ready) || ($urandom_range(3) != 0));
        o_b_resp   = wr_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    end

endmodule

// ==== test/tb_cache_axi_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_defines.svh"

module tb_cache_axi_bridge import axi_pkg::*, cache_line_pkg::*;
();

    localparam int LIMIT = 3000;   // cycles per wait

    logic aclk = 1'b0;
    logic aresetn = 1'b0;
    logic i_rd_valid = 1'b0;
    logic d_rd_valid = 1'b0;
    logic d_wr_valid = 1'b0;
    addr_t i_rd_addr = '0;
    addr_t d_rd_addr = '0;
    addr_t d_wr_addr = '0;
    line_t d_wr_line = '0;
    logic i_rd_ready, d_rd_ready, i_rsp_valid, d_rsp_valid, i_rsp_err, d_rsp_err;
    logic d_wr_ready, d_wr_done;
    line_t i_rsp_line, d_rsp_line;
    axi_resp_t d_wr_resp, r_resp, b_resp;
    logic [`AXI_ID_W-1:0] ar_id;
    addr_t ar_addr, aw_addr;
    axi_len_t ar_len, aw_len;
    axi_size_t ar_size, aw_size;
    axi_burst_t ar_burst, aw_burst;
    logic ar_valid, ar_ready, r_last, r_valid, r_ready, aw_valid, aw_ready;
    logic w_last, w_valid, w_ready, b_valid, b_ready;
    beat_t r_data, w_data;
    logic [3:0] w_strb;
    logic [9:0] seen_ar, seen_aw;

    logic [`AXI_ID_W-1:0] ar_id_q = '0;   // id of the last accepted AR
    axi_size_t ar_size_q = '0;
    axi_size_t aw_size_q = '0;
    logic [3:0] strb_all = 4'hF;          // strobes of the current burst ANDed

    logic [31:0] shadow [int];     // words written back so far
    string i_name[$], d_name[$], w_name[$];
    logic [512:0] i_exp[$], d_exp[$];   // err flag above the line
    axi_resp_t w_exp[$];
    addr_t w_addr[$];
    line_t w_line[$];
    int n_pass = 0;
    int n_fail = 0;
    int cyc = 0;
    int i_cyc = 0;
    int d_cyc = 0;

    always #2 aclk = ~aclk;

    cache_axi_bridge i_cache_axi_bridge
    (
        .aclk (aclk), .aresetn (aresetn),
        .i_i_rd_valid (i_rd_valid), .i_i_rd_addr (i_rd_addr), .o_i_rd_ready (i_rd_ready),
        .o_i_rsp_valid (i_rsp_valid), .o_i_rsp_line (i_rsp_line), .o_i_rsp_err (i_rsp_err),
        .i_d_rd_valid (d_rd_valid), .i_d_rd_addr (d_rd_addr), .o_d_rd_ready (d_rd_ready),
        .o_d_rsp_valid (d_rsp_valid), .o_d_rsp_line (d_rsp_line), .o_d_rsp_err (d_rsp_err),
        .i_d_wr_valid (d_wr_valid), .i_d_wr_addr (d_wr_addr), .i_d_wr_line (d_wr_line),
        .o_d_wr_ready (d_wr_ready), .o_d_wr_done (d_wr_done), .o_d_wr_resp (d_wr_resp),
        .o_ar_id (ar_id), .o_ar_addr (ar_addr), .o_ar_len (ar_len), .o_ar_size (ar_size),
        .o_ar_burst (ar_burst), .o_ar_valid (ar_valid), .i_ar_ready (ar_ready),
        .i_r_data (r_data), .i_r_resp (r_resp), .i_r_last (r_last), .i_r_valid (r_valid),
        .o_r_ready (r_ready),
        .o_aw_addr (aw_addr), .o_aw_len (aw_len), .o_aw_size (aw_size),
        .o_aw_burst (aw_burst), .o_aw_valid (aw_valid), .i_aw_ready (aw_ready),
        .o_w_data (w_data), .o_w_strb (w_strb), .o_w_last (w_last), .o_w_valid (w_valid),
        .i_w_ready (w_ready), .i_b_resp (b_resp), .i_b_valid (b_valid), .o_b_ready (b_ready)
    );

    axi_mem_model i_axi_mem_model
    (
        .aclk (aclk), .aresetn (aresetn),
        .i_ar_addr (ar_addr), .i_ar_len (ar_len), .i_ar_burst (ar_burst),
        .i_ar_valid (ar_valid), .o_ar_ready (ar_ready),
        .o_r_data (r_data), .o_r_resp (r_resp), .o_r_last (r_last), .o_r_valid (r_valid),
        .i_r_ready (r_ready),
        .i_aw_addr (aw_addr), .i_aw_len (aw_len), .i_aw_burst (aw_burst),
        .i_aw_valid (aw_valid), .o_aw_ready (aw_ready),
        .i_w_data (w_data), .i_w_last (w_last), .i_w_valid (w_valid), .o_w_ready (w_ready),
        .o_b_resp (b_resp), .o_b_valid (b_valid), .i_b_ready (b_ready),
        .o_seen_ar (seen_ar), .o_seen_aw (seen_aw)
    );

    function automatic logic in_window(input addr_t a);
        return (a >= 32'h0000_F000) && (a <= 32'h0000_FFFF);
    endfunction

    // memory holds this pattern until a line is written back
    function automatic logic [512:0] expected_read(input addr_t a);
        logic [512:0] r;
        addr_t w;
        r = '0;
        for (int b = 0; b < `LINE_BEATS; b++)
        begin
            w = a + 4 * b;
            r[b*32 +: 32] = shadow.exists(w) ? shadow[w] : (w * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
        end
        r[512] = in_window(a);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [512:0] exp,
                               input logic [512:0] act);
        if (exp !== act)
        begin
            $display("Error %s: expected %0h, actual %0h", name, exp, act);
            n_fail++;
        end
        else
        begin
            $display("ok %s", name);
            n_pass++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("test failed");
        $finish;
    endtask

    // compares every response pulse against the queued expectation
    always @(posedge aclk)
    begin
        cyc++;
        if (ar_valid && ar_ready)
        begin
            ar_id_q   = ar_id;
            ar_size_q = ar_size;
        end
        if (aw_valid && aw_ready)
            aw_size_q = aw_size;
        if (w_valid && w_ready)
            strb_all = strb_all & w_strb;
        if (d_rsp_valid)
        begin
            d_cyc = cyc;
            if (d_exp.size() == 0)
                check_value("unexpected dcache response", 0, 1);
            else
            begin
                check_value({d_name[0], " ar id and size"}, {4'd1, 3'd2}, {ar_id_q, ar_size_q});
                check_value(d_name.pop_front(), d_exp.pop_front(), {d_rsp_err, d_rsp_line});
            end
        end
        if (i_rsp_valid)
        begin
            i_cyc = cyc;
            if (i_exp.size() == 0)
                check_value("unexpected icache response", 0, 1);
            else
            begin
                check_value({i_name[0], " ar id and size"}, {4'd0, 3'd2}, {ar_id_q, ar_size_q});
                check_value(i_name.pop_front(), i_exp.pop_front(), {i_rsp_err, i_rsp_line});
            end
        end
        if (d_wr_done)
        begin
            if (w_exp.size() == 0)
                check_value("unexpected write completion", 0, 1);
            else
            begin
                check_value({w_name[0], " aw size and strobes"}, {3'd2, 4'hF},
                            {aw_size_q, strb_all});
                strb_all = 4'hF;
                check_value(w_name.pop_front(), w_exp[0], d_wr_resp);
                if (w_exp.pop_front() == AXI_RESP_OKAY)
                    for (int b = 0; b < `LINE_BEATS; b++)
                        shadow[w_addr[0] + 4 * b] = w_line[0][b*32 +: 32];
                void'(w_addr.pop_front());
                void'(w_line.pop_front());
            end
        end
    end

    task automatic read_line(input logic dside, input addr_t a, input string name);
        int n;
        n = 0;
        if (dside)
        begin
            d_name.push_back(name);
            d_exp.push_back(expected_read(a));
            d_rd_addr = a;
            d_rd_valid = 1'b1;
        end
        else
        begin
            i_name.push_back(name);
            i_exp.push_back(expected_read(a));
            i_rd_addr = a;
            i_rd_valid = 1'b1;
        end
        @(posedge aclk);
        while (!(dside ? d_rd_ready : i_rd_ready) && n < LIMIT)
        begin
            @(posedge aclk);
            n++;
        end
        if (n >= LIMIT)
            abort_run({"read request grant of ", name});
        #1;
        if (dside)
            d_rd_valid = 1'b0;
        else
            i_rd_valid = 1'b0;
    endtask

    task automatic write_line(input addr_t a, input line_t l, input string name);
        int n;
        n = 0;
        w_name.push_back(name);
        w_exp.push_back(in_window(a) ? AXI_RESP_SLVERR : AXI_RESP_OKAY);
        w_addr.push_back(a);
        w_line.push_back(l);
        d_wr_addr = a;
        d_wr_line = l;
        d_wr_valid = 1'b1;
        @(posedge aclk);
        while (!d_wr_ready && n < LIMIT)
        begin
            @(posedge aclk);
            n++;
        end
        if (n >= LIMIT)
            abort_run({"write request grant of ", name});
        #1;
        d_wr_valid = 1'b0;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while ((i_exp.size() + d_exp.size() + w_exp.size()) != 0 && n < LIMIT)
        begin
            @(posedge aclk);
            n++;
        end
        if (n >= LIMIT)
            abort_run({"responses of ", what});
        @(posedge aclk);
        #1;
    endtask

    function automatic line_t random_line();
        line_t l;
        for (int b = 0; b < `LINE_BEATS; b++)
            l[b*32 +: 32] = $urandom;
        return l;
    endfunction

    initial
    begin
        addr_t ra;
        addr_t wa;
        void'($urandom(68));
        repeat (4) @(posedge aclk);
        check_value("reset outputs idle", 0, {ar_valid, r_ready, aw_valid, w_valid, b_ready,
                    i_rsp_valid, d_rsp_valid, d_wr_done});
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        read_line(1'b0, 32'h0000_0100, "icache read");
        wait_idle("icache read");
        fork
            read_line(1'b1, 32'h0000_0200, "dcache read in tie");
            read_line(1'b0, 32'h0000_0240, "icache read in tie");
        join
        wait_idle("tie reads");
        check_value("dcache response first", 1, d_cyc < i_cyc);
        write_line(32'h0000_0400, random_line(), "writeback");
        wait_idle("writeback");
        check_value("aw len and burst", {8'd15, 2'b01}, seen_aw);   // 16 beats, INCR
        read_line(1'b1, 32'h0000_0400, "read after writeback");
        wait_idle("read after writeback");
        check_value("ar len and burst", {8'd15, 2'b01}, seen_ar);
        for (int k = 0; k < 10; k++)
        begin
            ra = $urandom_range(63) * 64;
            wa = $urandom_range(63) * 64;
            if (wa == ra)
                wa = (wa + 64) & 32'h0000_0FFF;   // never the line being read
            fork
                read_line(1'($urandom_range(1)), ra, $sformatf("mixed read %0d", k));
                write_line(wa, random_line(), $sformatf("mixed write %0d", k));
            join
            wait_idle("mixed traffic");
        end
        read_line(1'b0, 32'h0000_F040, "error window read");
        write_line(32'h0000_F080, random_line(), "error window write");
        wait_idle("error window");
        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== cache_axi_bridge.f ====
+incdir+hdl
hdl/axi_pkg.sv
hdl/cache_line_pkg.sv
hdl/line_req_if.sv
hdl/read_arbiter.sv
hdl/axi_line_reader.sv
hdl/beat_serializer.sv
hdl/axi_line_writer.sv
hdl/cache_axi_bridge.sv
test/axi_mem_model.sv
test/tb_cache_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_cache_axi_bridge \
    -f cache_axi_bridge.f \
    --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation returned an error status"
    exit 1
fi
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
